//--- design/linkStage.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module linkStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  nocPkg::routedFlitT    routed,
    output nocPkg::flitT          outFlits [`NUM_PORTS],
    input  logic [`NUM_PORTS-1:0] outReady,
    output logic                  stall
);

    logic targetFree;

    // ####################
    // Target check.
    // ####################

    // Free when empty, or when its flit leaves on this edge.
    assign targetFree = !outFlits[routed.outPort].valid || outReady[routed.outPort];

    assign stall = routed.flit.valid && !targetFree;

    // ####################
    // Output registers.
    // ####################

    // One register per direction. A full register keeps its flit until
    // the neighbour takes it.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int d = 0; d < `NUM_PORTS; d++)
                outFlits[d] <= '0;
        end
        else
        begin
            for (int d = 0; d < `NUM_PORTS; d++)
            begin
                if (routed.flit.valid && targetFree &&
                    routed.outPort == nocPkg::portIdx'(d))
                    outFlits[d] <= routed.flit;
                else if (outReady[d])
                    outFlits[d].valid <= 1'b0;
            end
        end
    end

endmodule

//--- design/meshRouter.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module meshRouter (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  myX,
    input  logic                  myY,
    input  nocPkg::flitT          inFlits [`NUM_PORTS],
    output logic [`NUM_PORTS-1:0] inReady,
    output nocPkg::flitT          outFlits [`NUM_PORTS],
    input  logic [`NUM_PORTS-1:0] outReady
);

    nocPkg::flitT       granted;
    nocPkg::routedFlitT routed;
    logic               linkStall;
    logic               routeStall;

    // Arbitration, route, link.
    portArbiter arbiter (
        .clk(clk), .rstN(rstN),
        .inFlits(inFlits),
        .inReady(inReady),
        .stall(routeStall),
        .granted(granted)
    );

    xyRouteStage route (
        .clk(clk), .rstN(rstN),
        .myX(myX), .myY(myY),
        .inFlit(granted),
        .stall(linkStall),
        .stallUp(routeStall),
        .routed(routed)
    );

    linkStage link (
        .clk(clk), .rstN(rstN),
        .routed(routed),
        .outFlits(outFlits),
        .outReady(outReady),
        .stall(linkStall)
    );

endmodule

//--- design/meshWithNodes.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module meshWithNodes (
    input  logic               clk,
    input  logic               rstN,
    input  nocPkg::flitT       injFlit,
    input  logic [`NODE_W-1:0] injSrc,
    output logic               injReady,
    input  logic [`ADDR_W-1:0] peekAddress,
    input  logic [`NODE_W-1:0] peekId,
    output logic [`DATA_W-1:0] peekData
);

    nocPkg::flitT            toRouter [`NUM_NODES][`NUM_PORTS];
    nocPkg::flitT            fromRouter [`NUM_NODES][`NUM_PORTS];
    wire [`NUM_PORTS-1:0]    routerInReady [`NUM_NODES];
    wire [`NUM_PORTS-1:0]    routerOutReady [`NUM_NODES];
    logic [`DATA_W-1:0]      ramPeek [`NUM_NODES];

    assign injReady = routerInReady[injSrc][nocPkg::LOCAL];
    assign peekData = ramPeek[peekId];

    for (genvar row = 0; row < `MESH_Y; row++)
    begin : rows
        for (genvar col = 0; col < `MESH_X; col++)
        begin : columns
            localparam int id = row * `MESH_X + col;
            localparam logic [`NODE_W-1:0] nodeId = id[`NODE_W-1:0];
            localparam logic [0:0] colBit = 1'(col);
            localparam logic [0:0] rowBit = 1'(row);

            // Injection reaches only the selected node.
            assign toRouter[id][nocPkg::LOCAL] = (injSrc == nodeId) ? injFlit : '0;
            assign routerOutReady[id][nocPkg::LOCAL] = 1'b1;

            // ####################
            // Neighbour links.
            // ####################

            if (row > 0)
            begin : northLink
                assign toRouter[id][nocPkg::NORTH] = fromRouter[id - `MESH_X][nocPkg::SOUTH];
                assign routerOutReady[id][nocPkg::NORTH] =
                    routerInReady[id - `MESH_X][nocPkg::SOUTH];
            end
            else
            begin : northEdge
                assign toRouter[id][nocPkg::NORTH] = '0;
                assign routerOutReady[id][nocPkg::NORTH] = 1'b1;
            end

            if (row < `MESH_Y - 1)
            begin : southLink
                assign toRouter[id][nocPkg::SOUTH] = fromRouter[id + `MESH_X][nocPkg::NORTH];
                assign routerOutReady[id][nocPkg::SOUTH] =
                    routerInReady[id + `MESH_X][nocPkg::NORTH];
            end
            else
            begin : southEdge
                assign toRouter[id][nocPkg::SOUTH] = '0;
                assign routerOutReady[id][nocPkg::SOUTH] = 1'b1;
            end

            if (col < `MESH_X - 1)
            begin : eastLink
                assign toRouter[id][nocPkg::EAST] = fromRouter[id + 1][nocPkg::WEST];
                assign routerOutReady[id][nocPkg::EAST] = routerInReady[id + 1][nocPkg::WEST];
            end
            else
            begin : eastEdge
                assign toRouter[id][nocPkg::EAST] = '0;
                assign routerOutReady[id][nocPkg::EAST] = 1'b1;
            end

            if (col > 0)
            begin : westLink
                assign toRouter[id][nocPkg::WEST] = fromRouter[id - 1][nocPkg::EAST];
                assign routerOutReady[id][nocPkg::WEST] = routerInReady[id - 1][nocPkg::EAST];
            end
            else
            begin : westEdge
                assign toRouter[id][nocPkg::WEST] = '0;
                assign routerOutReady[id][nocPkg::WEST] = 1'b1;
            end

            meshRouter router (
                .clk(clk), .rstN(rstN),
                .myX(colBit), .myY(rowBit),
                .inFlits(toRouter[id]),
                .inReady(routerInReady[id]),
                .outFlits(fromRouter[id]),
                .outReady(routerOutReady[id])
            );

            nodeRam ram (
                .clk(clk), .rstN(rstN),
                .inFlit(fromRouter[id][nocPkg::LOCAL]),
                .peekAddress(peekAddress),
                .peekData(ramPeek[id])
            );
        end
    end

endmodule

//--- design/nocPkg.sv
`include "noc_params.svh"

package nocPkg;

    // Router port numbers. Each one also indexes every port array.
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        NORTH = 3'd1,
        EAST  = 3'd2,
        SOUTH = 3'd3,
        WEST  = 3'd4
    } portIdx;

    // ####################
    // Write flit.
    // ####################

    typedef struct packed {
        logic               valid;
        logic               dstX;
        logic               dstY;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } flitT;

    // Flit tagged with the output chosen by the route stage.
    typedef struct packed {
        flitT   flit;
        portIdx outPort;
    } routedFlitT;

endpackage

//--- design/noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// ####################
// Mesh geometry.
// ####################

`define MESH_X 2
`define MESH_Y 2
`define NUM_NODES (`MESH_X * `MESH_Y)

// Node id width. The id is row * MESH_X + column.
`define NODE_W 2

// ####################
// Node memory and data.
// ####################

`define ADDR_W 4
`define DATA_W 16

// Local, north, east, south, west.
`define NUM_PORTS 5

`endif

//--- design/nodeRam.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module nodeRam (
    input  logic               clk,
    input  logic               rstN,
    input  nocPkg::flitT       inFlit,
    input  logic [`ADDR_W-1:0] peekAddress,
    output logic [`DATA_W-1:0] peekData
);

    logic [`DATA_W-1:0] mem [2**`ADDR_W];

    // ####################
    // Write port.
    // ####################

    // Every flit on the local output is a write.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int a = 0; a < 2**`ADDR_W; a++)
                mem[a] <= '0;
        end
        else if (inFlit.valid)
            mem[inFlit.addr] <= inFlit.data;
    end

    // Debug readback.
    assign peekData = mem[peekAddress];

endmodule

//--- design/portArbiter.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module portArbiter (
    input  logic                  clk,
    input  logic                  rstN,
    input  nocPkg::flitT          inFlits [`NUM_PORTS],
    output logic [`NUM_PORTS-1:0] inReady,
    input  logic                  stall,
    output nocPkg::flitT          granted
);

    nocPkg::portIdx lastQ;
    nocPkg::portIdx pick;
    nocPkg::flitT   holdQ;
    logic           found;
    logic           accept;
    int             cand;

    // ####################
    // Round-robin search.
    // ####################

    // Start one past the last granted port and take the first valid one.
    always_comb
    begin
        pick  = lastQ;
        found = 1'b0;
        cand  = 0;
        for (int i = 1; i <= `NUM_PORTS; i++)
        begin
            cand = (int'(lastQ) + i) % `NUM_PORTS;
            if (!found && inFlits[cand].valid)
            begin
                pick  = nocPkg::portIdx'(cand);
                found = 1'b1;
            end
        end
    end

    // Accept only while the holding register has room.
    assign accept = found && !holdQ.valid;

    always_comb
    begin
        inReady = '0;
        if (accept)
            inReady[pick] = 1'b1;
    end

    // ####################
    // Grant register.
    // ####################

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            lastQ   <= nocPkg::WEST;
            granted <= '0;
            holdQ   <= '0;
        end
        else
        begin
            if (accept)
                lastQ <= pick;
            if (!stall)
            begin
                if (holdQ.valid)
                begin
                    granted     <= holdQ;
                    holdQ.valid <= 1'b0;
                end
                else if (accept)
                    granted <= inFlits[pick];
                else
                    granted <= '0;
            end
            // Flit taken during a stall waits here.
            else if (accept)
                holdQ <= inFlits[pick];
        end
    end

endmodule

//--- design/xyRouteStage.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module xyRouteStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               myX,
    input  logic               myY,
    input  nocPkg::flitT       inFlit,
    input  logic               stall,
    output logic               stallUp,
    output nocPkg::routedFlitT routed
);

    nocPkg::routedFlitT nextRouted;

    // ####################
    // XY decision.
    // ####################

    // Column first, then row. Row numbers grow to the south.
    always_comb
    begin
        nextRouted.flit = inFlit;
        if (inFlit.dstX != myX)
        begin
            if (inFlit.dstX > myX)
                nextRouted.outPort = nocPkg::EAST;
            else
                nextRouted.outPort = nocPkg::WEST;
        end
        else if (inFlit.dstY != myY)
        begin
            if (inFlit.dstY > myY)
                nextRouted.outPort = nocPkg::SOUTH;
            else
                nextRouted.outPort = nocPkg::NORTH;
        end
        else
            nextRouted.outPort = nocPkg::LOCAL;
    end

    // ####################
    // Route register.
    // ####################

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            routed <= '0;
        else if (!stall)
            routed <= nextRouted;
    end

    // The arbiter holds whenever this stage holds.
    assign stallUp = stall;

endmodule

//--- dv/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    // 40 ns period.
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset spans two rising edges and releases just after the second.
    initial
    begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;
    end

endmodule

//--- dv/meshWithNodesTb.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module meshWithNodesTb;

    logic               clk;
    logic               rstN;
    nocPkg::flitT       injFlit;
    logic [`NODE_W-1:0] injSrc;
    logic               injReady;
    logic [`ADDR_W-1:0] peekAddress;
    logic [`NODE_W-1:0] peekId;
    logic [`DATA_W-1:0] peekData;

    // Expected contents of every node memory.
    logic [`DATA_W-1:0] model [`NUM_NODES][2**`ADDR_W];

    int errorCount = 0;
    int testCount = 0;
    int errorsBefore = 0;
    int compareReq = 0;
    int compareAck = 0;

    clockGen clocks (.clk(clk), .rstN(rstN));

    meshWithNodes UUT (
        .clk(clk), .rstN(rstN),
        .injFlit(injFlit), .injSrc(injSrc), .injReady(injReady),
        .peekAddress(peekAddress), .peekId(peekId), .peekData(peekData)
    );

    // ####################
    // Reference and checks.
    // ####################

    // Column in the low bit of the node id.
    function automatic int nodeOf(input int dstX, input int dstY);
        return dstY * `MESH_X + dstX;
    endfunction

    function automatic logic [`DATA_W-1:0] expectedWord(input int node, input int addr);
        return model[node][addr];
    endfunction

    task automatic checkEqual(input string name, input logic [`DATA_W-1:0] expected,
                              input logic [`DATA_W-1:0] actual);
        if (expected !== actual)
        begin
            $display("error %s expected 0x%h actual 0x%h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic abortOnTimeout(input string why);
        $display("timeout, %s", why);
        $display("=== FAIL ===");
        $finish;
    endtask

    // Walks all nodes and addresses whenever a request is posted.
    initial
    begin : compareProcess
        int idle;
        peekId = '0;
        peekAddress = '0;
        forever
        begin
            idle = 0;
            while (compareReq == compareAck)
            begin
                @(posedge clk);
                idle++;
                if (idle > 5000)
                    abortOnTimeout("the compare process got no request");
            end
            for (int n = 0; n < `NUM_NODES; n++)
            begin
                for (int a = 0; a < 2**`ADDR_W; a++)
                begin
                    @(posedge clk);
                    #2;
                    peekId = n[`NODE_W-1:0];
                    peekAddress = a[`ADDR_W-1:0];
                    @(negedge clk);
                    checkEqual("peekData", expectedWord(n, a), peekData);
                end
            end
            compareAck = compareReq;
        end
    end

    // ####################
    // Stimulus tasks.
    // ####################

    task automatic waitReset();
        int waited;
        waited = 0;
        while (!rstN)
        begin
            @(posedge clk);
            waited++;
            if (waited > 10)
                abortOnTimeout("reset was never released");
        end
        @(posedge clk);
        #2;
    endtask

    // Holds the flit until the source router takes it.
    task automatic injectFlit(input int src, input int dx, input int dy,
                              input int addr, input int data);
        int waited;
        waited = 0;
        injSrc = src[`NODE_W-1:0];
        injFlit.valid = 1'b1;
        injFlit.dstX = dx[0];
        injFlit.dstY = dy[0];
        injFlit.addr = addr[`ADDR_W-1:0];
        injFlit.data = data[`DATA_W-1:0];
        @(negedge clk);
        while (!injReady)
        begin
            waited++;
            if (waited > 200)
                abortOnTimeout("injReady stayed low at the source node");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        injFlit = '0;
        model[nodeOf(dx, dy)][addr] = data[`DATA_W-1:0];
    endtask

    task automatic drainNetwork(input int cycles);
        for (int c = 0; c < cycles; c++)
            @(posedge clk);
        #2;
    endtask

    task automatic runCompare();
        int waited;
        waited = 0;
        compareReq++;
        while (compareAck != compareReq)
        begin
            @(posedge clk);
            waited++;
            if (waited > 200)
                abortOnTimeout("the memory compare did not finish");
        end
        #2;
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("test %0d %s, %0d errors", testCount, name, errorCount - errorsBefore);
        errorsBefore = errorCount;
    endtask

    // ####################
    // Test sequence.
    // ####################

    initial
    begin : mainSequence
        bit used [`NUM_NODES * 2**`ADDR_W];
        int pair;
        int node;
        injFlit = '0;
        injSrc = '0;
        void'($urandom(32'h1c87));
        for (int n = 0; n < `NUM_NODES; n++)
            for (int a = 0; a < 2**`ADDR_W; a++)
                model[n][a] = '0;
        for (int p = 0; p < `NUM_NODES * 2**`ADDR_W; p++)
            used[p] = 1'b0;
        waitReset();

        runCompare();
        finishTest("reset clears memories");

        injectFlit(0, 0, 0, 3, 'h1111);
        injectFlit(3, 1, 1, 5, 'h2222);
        drainNetwork(40);
        runCompare();
        finishTest("local writes");

        // East, west, south, north.
        injectFlit(0, 1, 0, 1, 'hA001);
        injectFlit(1, 0, 0, 2, 'hA002);
        injectFlit(0, 0, 1, 4, 'hA003);
        injectFlit(2, 0, 0, 6, 'hA004);
        drainNetwork(40);
        runCompare();
        finishTest("single hops");

        injectFlit(0, 1, 1, 7, 'hB001);
        injectFlit(3, 0, 0, 8, 'hB002);
        injectFlit(1, 0, 1, 9, 'hB003);
        injectFlit(1, 0, 1, 9, 'hB004);
        drainNetwork(40);
        runCompare();
        finishTest("diagonal hops and overwrite");

        // Distinct targets keep the result independent of arrival order.
        for (int k = 0; k < 60; k++)
        begin
            pair = int'($urandom_range(`NUM_NODES * 2**`ADDR_W - 1, 0));
            while (used[pair])
                pair = (pair + 1) % (`NUM_NODES * 2**`ADDR_W);
            used[pair] = 1'b1;
            node = pair / 2**`ADDR_W;
            injectFlit(int'($urandom_range(`NUM_NODES - 1, 0)), node % `MESH_X,
                       node / `MESH_X, pair % 2**`ADDR_W, int'($urandom));
        end
        drainNetwork(40);
        runCompare();
        finishTest("random burst");

        $display("tests %0d errors %0d", testCount, errorCount);
        if (errorCount == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- dv/meshWithNodes_props.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module meshRouterProps (
    input logic                  clk,
    input logic                  rstN,
    input logic [`NUM_PORTS-1:0] inReady,
    input nocPkg::flitT          outFlits [`NUM_PORTS],
    input logic [`NUM_PORTS-1:0] outReady
);

    logic [`NUM_PORTS-1:0] outValid;

    always_comb
    begin
        for (int d = 0; d < `NUM_PORTS; d++)
            outValid[d] = outFlits[d].valid;
    end

    // A blocked output keeps its flit.
    for (genvar d = 0; d < `NUM_PORTS; d++)
    begin : holdChecks
        assert property (@(posedge clk) disable iff (!rstN)
            outFlits[d].valid && !outReady[d] |=> $stable(outFlits[d]))
            else $error("router output %0d changed while blocked", d);
    end

    // One input granted at a time.
    assert property (@(posedge clk) disable iff (!rstN) $onehot0(inReady))
        else $error("more than one router input ready");

    assert property (@(posedge clk) (!$past(rstN) || !$past(rstN, 2)) |-> outValid == '0)
        else $error("router output valid right after reset");

endmodule

bind meshRouter meshRouterProps props (
    .clk(clk),
    .rstN(rstN),
    .inReady(inReady),
    .outFlits(outFlits),
    .outReady(outReady)
);

//--- flist.f
+incdir+design
design/nocPkg.sv
design/portArbiter.sv
design/xyRouteStage.sv
design/linkStage.sv
design/meshRouter.sv
design/nodeRam.sv
design/meshWithNodes.sv
dv/clockGen.sv
dv/meshWithNodes_props.sv
dv/meshWithNodesTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module meshWithNodesTb -o simv

# The log is searched below, so a nonzero simulator exit is not fatal here.
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log
then
    exit 0
fi
exit 1
